/* hc_pkg.sv */
// Package with line and address widths, request types, FSM states and control words.

package hc_pkg;

  localparam int HC_LINE_WIDTH  = 64;
  localparam int HC_WORD_WIDTH  = 32;
  localparam int HC_ADDR_WIDTH  = 16;
  localparam int HC_ARG_WIDTH   = 10;
  localparam int HC_BUFFER_SIZE = 2; // Buffer 0 is the source, buffer 1 the destination.

  // Control words written by the host.
  localparam logic [31:0] HC_CONTROL_START         = 32'h0000_0001;
  localparam logic [31:0] HC_CONTROL_START_REVERSE = 32'h0000_0003;

  typedef enum logic [1:0] {
    e_REQUEST_NONE         = 2'd0,
    e_REQUEST_READ_STREAM  = 2'd1,
    e_REQUEST_READ_INDEXED = 2'd2,
    e_REQUEST_WRITE_STREAM = 2'd3
  } t_request_cmd;

  // Line count for stream reads, line offset for indexed reads.
  typedef union packed {
    logic [HC_ARG_WIDTH-1:0] length;
    logic [HC_ARG_WIDTH-1:0] index;
  } t_request_arg;

  typedef struct packed {
    t_request_cmd cmd;
    logic         id;
    t_request_arg arg;
  } t_request_control;

  typedef enum logic [1:0] {
    S_RD_START,
    S_RD_IDLE,
    S_RD_STREAM,
    S_RD_INDEX
  } t_rd_state;

  typedef enum logic [2:0] {
    S_WR_IDLE,
    S_WR_WAIT,
    S_WR_SEND,
    S_WR_FINISH,
    S_WR_DONE
  } t_wr_state;

endpackage : hc_pkg

/* hc_buffers_if.sv */
// Interface between the line-copy core and the requestor, with its two modports.

`timescale 1ns/1ps

interface hc_buffers_if;

  hc_pkg::t_request_control read_request; // Command is none outside an enqueue cycle.
  logic                     read_full;

  logic                               rx_valid;
  logic [hc_pkg::HC_LINE_WIDTH-1:0]   rx_data;

  logic                               write_request; // Write-stream strobe.
  logic [hc_pkg::HC_LINE_WIDTH-1:0]   tx_data;
  logic                               write_full;

  logic finish;
  logic start;
  logic mode_reverse;

  modport core (
    output read_request,
    input  read_full,
    input  rx_valid,
    input  rx_data,
    output write_request,
    output tx_data,
    input  write_full,
    output finish,
    input  start,
    input  mode_reverse
  );

  modport requestor (
    input  read_request,
    output read_full,
    output rx_valid,
    output rx_data,
    input  write_request,
    input  tx_data,
    output write_full,
    input  finish,
    output start,
    output mode_reverse
  );

endinterface : hc_buffers_if

/* hc_fifo.sv */
// Synchronous circular-buffer FIFO with show-ahead output and occupancy counter.

`timescale 1ns/1ps

module hc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [WIDTH-1:0]           enq_data,
  input  logic                       enq_en,
  output logic                       not_full,
  output logic [WIDTH-1:0]           deq_data,
  input  logic                       deq_en,
  output logic                       not_empty,
  output logic [$clog2(DEPTH+1)-1:0] counter
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;

  assign not_full  = (counter != DEPTH);
  assign not_empty = (counter != 0);
  assign deq_data  = mem[rd_ptr]; // Show-ahead.

  always_ff @(posedge clk) begin
    if (enq_en) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      counter <= '0;
    end else begin
      if (enq_en) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_en) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({enq_en, deq_en})
        2'b10:   counter <= counter + 1'b1;
        2'b01:   counter <= counter - 1'b1;
        default: counter <= counter;
      endcase
    end
  end

  overflow_check: assert property (
    @(posedge clk) disable iff (reset) enq_en |-> not_full
  ) else $error("hc_fifo: enqueue while full");

  underflow_check: assert property (
    @(posedge clk) disable iff (reset) deq_en |-> not_empty
  ) else $error("hc_fifo: dequeue while empty");

endmodule : hc_fifo

/* hc_line_core.sv */
// Line-copy core: issues read requests, increments returned lines, queues writes.

`timescale 1ns/1ps

module hc_line_core (
  input logic                             clk,
  input logic                             reset,
  input logic [hc_pkg::HC_ADDR_WIDTH-1:0] src_lines,
  hc_buffers_if.core                      buffers
);

  localparam int WORDS = hc_pkg::HC_LINE_WIDTH / hc_pkg::HC_WORD_WIDTH;

  logic                             start_q;
  logic                             start_rise;
  logic                             rd_active;
  logic [hc_pkg::HC_ADDR_WIDTH-1:0] rd_index;
  logic [hc_pkg::HC_ADDR_WIDTH-1:0] wr_count;
  logic                             running;

  assign start_rise = buffers.start && !start_q;

  // Request side. Reverse mode walks the indices down from the last line.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      start_q              <= 1'b0;
      rd_active            <= 1'b0;
      rd_index             <= '0;
      buffers.read_request <= '0;
    end else begin
      start_q              <= buffers.start;
      buffers.read_request <= '0;
      if (start_rise) begin
        rd_active <= (src_lines != '0);
        rd_index  <= src_lines - 1'b1;
      end else if (rd_active && !buffers.read_full) begin
        if (buffers.mode_reverse) begin
          buffers.read_request.cmd       <= hc_pkg::e_REQUEST_READ_INDEXED;
          buffers.read_request.arg.index <= rd_index[hc_pkg::HC_ARG_WIDTH-1:0];
          rd_active                      <= (rd_index != '0);
          rd_index                       <= rd_index - 1'b1;
        end else begin
          buffers.read_request.cmd        <= hc_pkg::e_REQUEST_READ_STREAM;
          buffers.read_request.arg.length <= src_lines[hc_pkg::HC_ARG_WIDTH-1:0];
          rd_active                       <= 1'b0; // One stream covers the buffer.
        end
      end
    end
  end

  // Write side and completion.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      buffers.write_request <= 1'b0;
      buffers.finish        <= 1'b0;
      wr_count              <= '0;
      running               <= 1'b0;
    end else begin
      buffers.write_request <= buffers.rx_valid;
      if (buffers.rx_valid) begin
        wr_count <= wr_count + 1'b1;
      end
      if (start_rise) begin
        running <= 1'b1;
      end
      buffers.finish <= running && (wr_count == src_lines);
    end
  end

  // Each 32-bit word gets one added, wrapping.
  always_ff @(posedge clk) begin
    if (buffers.rx_valid) begin
      for (int w = 0; w < WORDS; w++) begin
        buffers.tx_data[w*hc_pkg::HC_WORD_WIDTH +: hc_pkg::HC_WORD_WIDTH] <=
          buffers.rx_data[w*hc_pkg::HC_WORD_WIDTH +: hc_pkg::HC_WORD_WIDTH] + 1'b1;
      end
    end
  end

  // The requestor throttles reads so the write queue keeps room.
  write_room_check: assert property (
    @(posedge clk) disable iff (reset) buffers.write_request |-> !buffers.write_full
  ) else $error("hc_line_core: write enqueue while write queue full");

endmodule : hc_line_core

/* hc_requestor.sv */
// Requestor: control register, read and write queues, read FSM, write FSM, completion write.

`timescale 1ns/1ps

module hc_requestor #(
  parameter int REQUEST_DEPTH = 8,
  parameter int TX_DEPTH      = 16
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [31:0]                      hc_control,
  input  logic [hc_pkg::HC_ADDR_WIDTH-1:0] dsm_base,
  input  logic [hc_pkg::HC_ADDR_WIDTH-1:0] src_base,
  input  logic [hc_pkg::HC_ADDR_WIDTH-1:0] dst_base,
  output logic                             c0_valid,
  output logic [hc_pkg::HC_ADDR_WIDTH-1:0] c0_addr,
  input  logic                             c0_almost_full,
  input  logic                             c0_rsp_valid,
  input  logic [hc_pkg::HC_LINE_WIDTH-1:0] c0_rsp_data,
  output logic                             c1_valid,
  output logic [hc_pkg::HC_ADDR_WIDTH-1:0] c1_addr,
  output logic [hc_pkg::HC_LINE_WIDTH-1:0] c1_data,
  input  logic                             c1_almost_full,
  hc_buffers_if.requestor                  buffers
);

  logic [hc_pkg::HC_ADDR_WIDTH-1:0] buffer_base [hc_pkg::HC_BUFFER_SIZE];

  logic                                 rq_enq_en;
  logic                                 rq_deq_en;
  logic                                 rq_not_empty;
  logic [$clog2(REQUEST_DEPTH+1)-1:0]   rq_counter;
  hc_pkg::t_request_control             rq_deq_data;
  hc_pkg::t_request_control             rd_request;

  hc_pkg::t_rd_state                    rd_state;
  logic [hc_pkg::HC_ARG_WIDTH-1:0]      rd_offset;
  logic [hc_pkg::HC_ADDR_WIDTH-1:0]     rd_line;
  logic                                 rd_issue;
  logic [$clog2(TX_DEPTH+1)-1:0]        rd_outstanding;
  logic                                 tx_room;

  logic                                 wq_deq_en;
  logic                                 wq_not_empty;
  logic [$clog2(TX_DEPTH+1)-1:0]        wq_counter;
  logic [hc_pkg::HC_LINE_WIDTH-1:0]     wq_deq_data;

  hc_pkg::t_wr_state                    wr_state;
  logic [hc_pkg::HC_ADDR_WIDTH-1:0]     wr_offset;
  logic                                 dsm_write;

  assign buffer_base[0] = src_base;
  assign buffer_base[1] = dst_base;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      buffers.start        <= 1'b0;
      buffers.mode_reverse <= 1'b0;
    end else begin
      buffers.start <= (hc_control == hc_pkg::HC_CONTROL_START) ||
                       (hc_control == hc_pkg::HC_CONTROL_START_REVERSE);
      buffers.mode_reverse <= (hc_control == hc_pkg::HC_CONTROL_START_REVERSE);
    end
  end

  assign rq_enq_en = (buffers.read_request.cmd == hc_pkg::e_REQUEST_READ_STREAM) ||
                     (buffers.read_request.cmd == hc_pkg::e_REQUEST_READ_INDEXED);

  hc_fifo #(
    .WIDTH ($bits(hc_pkg::t_request_control)),
    .DEPTH (REQUEST_DEPTH)
  ) read_queue_i (
    .clk       (clk),
    .reset     (reset),
    .enq_data  (buffers.read_request),
    .enq_en    (rq_enq_en),
    .not_full  (),
    .deq_data  (rq_deq_data),
    .deq_en    (rq_deq_en),
    .not_empty (rq_not_empty),
    .counter   (rq_counter)
  );

  assign buffers.read_full = (rq_counter > (REQUEST_DEPTH - 4));

  // Queued plus in-flight lines must leave the write queue below its full mark.
  assign tx_room  = (int'(wq_counter) + int'(rd_outstanding)) < (TX_DEPTH - 3);
  assign rd_issue = ((rd_state == hc_pkg::S_RD_STREAM) || (rd_state == hc_pkg::S_RD_INDEX)) &&
                    !c0_almost_full && tx_room;
  assign rq_deq_en = (rd_state == hc_pkg::S_RD_IDLE) && rq_not_empty;

  always_comb begin
    rd_line = '0;
    if (rd_state == hc_pkg::S_RD_STREAM) begin
      rd_line[hc_pkg::HC_ARG_WIDTH-1:0] = rd_offset;
    end else begin
      rd_line[hc_pkg::HC_ARG_WIDTH-1:0] = rd_request.arg.index;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state  <= hc_pkg::S_RD_START;
      rd_offset <= '0;
      c0_valid  <= 1'b0;
    end else begin
      c0_valid <= rd_issue;
      case (rd_state)
        hc_pkg::S_RD_START: begin
          if (buffers.start) begin
            rd_state <= hc_pkg::S_RD_IDLE;
          end
        end
        hc_pkg::S_RD_IDLE: begin
          rd_offset <= '0;
          if (rq_not_empty) begin
            if (rq_deq_data.cmd == hc_pkg::e_REQUEST_READ_INDEXED) begin
              rd_state <= hc_pkg::S_RD_INDEX;
            end else if (rq_deq_data.arg.length != '0) begin
              rd_state <= hc_pkg::S_RD_STREAM;
            end
          end
        end
        hc_pkg::S_RD_STREAM: begin
          if (rd_issue) begin
            rd_offset <= rd_offset + 1'b1;
            if ((rd_offset + 1'b1) == rd_request.arg.length) begin
              rd_state <= hc_pkg::S_RD_IDLE;
            end
          end
        end
        hc_pkg::S_RD_INDEX: begin
          if (rd_issue) begin
            rd_state <= hc_pkg::S_RD_IDLE;
          end
        end
        default: rd_state <= hc_pkg::S_RD_START;
      endcase
    end
  end

  // Lines issued on c0 and not yet back in the write queue.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_outstanding <= '0;
    end else begin
      case ({rd_issue, buffers.write_request})
        2'b10:   rd_outstanding <= rd_outstanding + 1'b1;
        2'b01:   rd_outstanding <= rd_outstanding - 1'b1;
        default: rd_outstanding <= rd_outstanding;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      buffers.rx_valid <= 1'b0;
    end else begin
      buffers.rx_valid <= c0_rsp_valid;
    end
  end

  hc_fifo #(
    .WIDTH (hc_pkg::HC_LINE_WIDTH),
    .DEPTH (TX_DEPTH)
  ) write_queue_i (
    .clk       (clk),
    .reset     (reset),
    .enq_data  (buffers.tx_data),
    .enq_en    (buffers.write_request),
    .not_full  (),
    .deq_data  (wq_deq_data),
    .deq_en    (wq_deq_en),
    .not_empty (wq_not_empty),
    .counter   (wq_counter)
  );

  assign buffers.write_full = (wq_counter > (TX_DEPTH - 4));

  assign wq_deq_en = (wr_state == hc_pkg::S_WR_SEND) && wq_not_empty && !c1_almost_full;
  assign dsm_write = (wr_state == hc_pkg::S_WR_FINISH) && !c1_almost_full;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state  <= hc_pkg::S_WR_IDLE;
      wr_offset <= '0;
      c1_valid  <= 1'b0;
    end else begin
      c1_valid <= wq_deq_en || dsm_write;
      case (wr_state)
        hc_pkg::S_WR_IDLE: begin
          if (buffers.start) begin
            wr_state <= hc_pkg::S_WR_WAIT;
          end
        end
        hc_pkg::S_WR_WAIT: begin
          if (wq_not_empty) begin
            wr_state <= hc_pkg::S_WR_SEND;
          end else if (buffers.finish) begin
            wr_state <= hc_pkg::S_WR_FINISH;
          end
        end
        hc_pkg::S_WR_SEND: begin
          if (wq_deq_en) begin
            wr_offset <= wr_offset + 1'b1;
          end
          if (!wq_not_empty) begin
            wr_state <= hc_pkg::S_WR_WAIT;
          end
        end
        hc_pkg::S_WR_FINISH: begin
          if (dsm_write) begin
            wr_state <= hc_pkg::S_WR_DONE;
          end
        end
        default: wr_state <= hc_pkg::S_WR_DONE; // Held until reset.
      endcase
    end
  end

  // Payload registers.
  always_ff @(posedge clk) begin
    if (rq_deq_en) begin
      rd_request <= rq_deq_data;
    end
    if (rd_issue) begin
      c0_addr <= buffer_base[rd_request.id] + rd_line;
    end
    if (c0_rsp_valid) begin
      buffers.rx_data <= c0_rsp_data;
    end
    if (dsm_write) begin
      c1_addr <= dsm_base;
      c1_data <= {{(hc_pkg::HC_LINE_WIDTH-1){1'b0}}, 1'b1};
    end else if (wq_deq_en) begin
      c1_addr <= buffer_base[1] + wr_offset;
      c1_data <= wq_deq_data;
    end
  end

  c0_flow_check: assert property (
    @(posedge clk) disable iff (reset) c0_almost_full |=> !c0_valid
  ) else $error("hc_requestor: c0 read issued after almost-full");

  // The completion write is the last c1 request of a run.
  single_completion_check: assert property (
    @(posedge clk) disable iff (reset) (wr_state == hc_pkg::S_WR_DONE) |=> !c1_valid
  ) else $error("hc_requestor: c1 write after completion");

endmodule : hc_requestor

/* hc_top.sv */
// RTL top level joining the line-copy core and the requestor over the buffer interface.

`timescale 1ns/1ps

module hc_top #(
  parameter int REQUEST_DEPTH = 8,
  parameter int TX_DEPTH      = 16
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [31:0]                      hc_control,
  input  logic [hc_pkg::HC_ADDR_WIDTH-1:0] dsm_base,
  input  logic [hc_pkg::HC_ADDR_WIDTH-1:0] src_base,
  input  logic [hc_pkg::HC_ADDR_WIDTH-1:0] dst_base,
  input  logic [hc_pkg::HC_ADDR_WIDTH-1:0] src_lines,
  output logic                             c0_valid,
  output logic [hc_pkg::HC_ADDR_WIDTH-1:0] c0_addr,
  input  logic                             c0_almost_full,
  input  logic                             c0_rsp_valid,
  input  logic [hc_pkg::HC_LINE_WIDTH-1:0] c0_rsp_data,
  output logic                             c1_valid,
  output logic [hc_pkg::HC_ADDR_WIDTH-1:0] c1_addr,
  output logic [hc_pkg::HC_LINE_WIDTH-1:0] c1_data,
  input  logic                             c1_almost_full
);

  hc_buffers_if buffers ();

  hc_line_core core_i (
    .clk       (clk),
    .reset     (reset),
    .src_lines (src_lines),
    .buffers   (buffers.core)
  );

  hc_requestor #(
    .REQUEST_DEPTH (REQUEST_DEPTH),
    .TX_DEPTH      (TX_DEPTH)
  ) requestor_i (
    .clk            (clk),
    .reset          (reset),
    .hc_control     (hc_control),
    .dsm_base       (dsm_base),
    .src_base       (src_base),
    .dst_base       (dst_base),
    .c0_valid       (c0_valid),
    .c0_addr        (c0_addr),
    .c0_almost_full (c0_almost_full),
    .c0_rsp_valid   (c0_rsp_valid),
    .c0_rsp_data    (c0_rsp_data),
    .c1_valid       (c1_valid),
    .c1_addr        (c1_addr),
    .c1_data        (c1_data),
    .c1_almost_full (c1_almost_full),
    .buffers        (buffers.requestor)
  );

endmodule : hc_top

/* hc_host_model.sv */
// Testbench host memory with in-order read responses, write capture and almost-full patterns.

`timescale 1ns/1ps

module hc_host_model (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             c0_valid,
  input  logic [hc_pkg::HC_ADDR_WIDTH-1:0] c0_addr,
  output logic                             c0_almost_full,
  output logic                             c0_rsp_valid,
  output logic [hc_pkg::HC_LINE_WIDTH-1:0] c0_rsp_data,
  input  logic                             c1_valid,
  input  logic [hc_pkg::HC_ADDR_WIDTH-1:0] c1_addr,
  input  logic [hc_pkg::HC_LINE_WIDTH-1:0] c1_data,
  output logic                             c1_almost_full,
  input  logic [15:0]                      c0_af_pattern,
  input  logic [15:0]                      c1_af_pattern
);

  logic [hc_pkg::HC_LINE_WIDTH-1:0] mem [64];
  logic                             rd_pending;
  logic [5:0]                       rd_line;
  logic [3:0]                       phase;

  // Each read is answered two cycles after its request.
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_pending     <= 1'b0;
      rd_line        <= '0;
      c0_rsp_valid   <= 1'b0;
      c0_rsp_data    <= '0;
      phase          <= '0;
      c0_almost_full <= 1'b0;
      c1_almost_full <= 1'b0;
    end else begin
      rd_pending     <= c0_valid;
      rd_line        <= c0_addr[5:0];
      c0_rsp_valid   <= rd_pending;
      c0_rsp_data    <= mem[rd_line];
      phase          <= phase + 1'b1;
      c0_almost_full <= c0_af_pattern[phase]; // Pattern repeats every 16 cycles.
      c1_almost_full <= c1_af_pattern[phase];
    end
  end

  always @(posedge clk) begin
    if (c1_valid) begin
      mem[c1_addr[5:0]] <= c1_data;
    end
  end

  // Preload of one line.
  task automatic load_line(input logic [15:0] addr, input logic [63:0] data);
    mem[addr[5:0]] = data;
  endtask

  function automatic logic [63:0] read_line(input logic [15:0] addr);
    return mem[addr[5:0]];
  endfunction

endmodule : hc_host_model

/* hc_tb.sv */
// Testbench top with clock, reset, test sequence, port assertions, LCG and reporting.

`timescale 1ns/1ps

module hc_tb;

  localparam int NUM_TESTS = 8;

  logic        clk;
  logic        reset;
  logic [31:0] hc_control;
  logic [15:0] dsm_base;
  logic [15:0] src_base;
  logic [15:0] dst_base;
  logic [15:0] src_lines;
  logic        c0_valid;
  logic [15:0] c0_addr;
  logic        c0_almost_full;
  logic        c0_rsp_valid;
  logic [63:0] c0_rsp_data;
  logic        c1_valid;
  logic [15:0] c1_addr;
  logic [63:0] c1_data;
  logic        c1_almost_full;
  logic [15:0] c0_af_pattern;
  logic [15:0] c1_af_pattern;

  logic [31:0] rand_state;
  logic [63:0] src_data [16];
  logic [15:0] test_n [NUM_TESTS];
  logic        test_rev [NUM_TESTS];
  logic [15:0] test_c0_pat [NUM_TESTS];
  logic [15:0] test_c1_pat [NUM_TESTS];
  logic        reverse_mode;
  logic [15:0] rd_count;
  logic [15:0] wr_count;
  logic [15:0] dsm_count;
  logic [15:0] src_index;
  logic [15:0] exp_rd_addr;
  logic [63:0] exp_wr_data;
  int          error_count;
  int          failed_tests;
  int          cycle_count;
  int          cycle_limit;

  hc_top hc_top_i (.*);

  hc_host_model host_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  function automatic logic [63:0] increment_words(input logic [63:0] line);
    return {line[63:32] + 32'd1, line[31:0] + 32'd1};
  endfunction

  function automatic logic [63:0] fill_line(input int addr);
    return {32'hFEED_0000 | 32'(addr), 32'hBEEF_0000 | 32'(addr)};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("[FAIL] %s: got %h expected %h", name, got, exp);
    error_count++;
  endtask

  task automatic report_error(input string what);
    $display("Error: %s", what);
    error_count++;
  endtask

  // Port traffic counters, cleared by every test reset.
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_count  <= '0;
      wr_count  <= '0;
      dsm_count <= '0;
    end else begin
      if (c0_valid) rd_count <= rd_count + 1'b1;
      if (c1_valid && c1_addr == dsm_base) begin
        dsm_count <= dsm_count + 1'b1;
      end else if (c1_valid) begin
        wr_count <= wr_count + 1'b1;
      end
    end
  end

  always_comb begin
    src_index   = reverse_mode ? (src_lines - 16'd1 - wr_count) : wr_count;
    exp_wr_data = increment_words(src_data[src_index[3:0]]);
    exp_rd_addr = src_base + (reverse_mode ? (src_lines - 16'd1 - rd_count) : rd_count);
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run still busy after %0d cycles", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  idle_check: assert property (@(posedge clk) disable iff (reset)
    (hc_control == 32'h0) |-> (!c0_valid && !c1_valid))
    else report_mismatch("{c0_valid,c1_valid}", $sampled({c0_valid, c1_valid}), 64'h0);
  c0_flow_check: assert property (@(posedge clk) disable iff (reset)
    c0_almost_full |=> !c0_valid)
    else report_mismatch("c0_valid after c0_almost_full", $sampled(c0_valid), 64'h0);
  c1_flow_check: assert property (@(posedge clk) disable iff (reset)
    c1_almost_full |=> !c1_valid)
    else report_mismatch("c1_valid after c1_almost_full", $sampled(c1_valid), 64'h0);
  read_range_check: assert property (@(posedge clk) disable iff (reset)
    c0_valid |-> (c0_addr >= src_base) && (c0_addr < src_base + src_lines))
    else report_error($sformatf("c0_addr %h outside the source buffer", $sampled(c0_addr)));
  read_order_check: assert property (@(posedge clk) disable iff (reset)
    c0_valid |-> (c0_addr == exp_rd_addr))
    else report_mismatch("c0_addr", $sampled(c0_addr), $sampled(exp_rd_addr));
  write_range_check: assert property (@(posedge clk) disable iff (reset)
    c1_valid |-> (c1_addr == dsm_base) ||
                 ((c1_addr >= dst_base) && (c1_addr < dst_base + src_lines)))
    else report_error($sformatf("c1_addr %h outside the destination buffer", $sampled(c1_addr)));
  write_addr_check: assert property (@(posedge clk) disable iff (reset)
    (c1_valid && c1_addr != dsm_base) |-> (c1_addr == dst_base + wr_count))
    else report_mismatch("c1_addr", $sampled(c1_addr), $sampled(dst_base + wr_count));
  write_data_check: assert property (@(posedge clk) disable iff (reset)
    (c1_valid && c1_addr != dsm_base) |-> (c1_data == exp_wr_data))
    else report_mismatch("c1_data", $sampled(c1_data), $sampled(exp_wr_data));
  completion_data_check: assert property (@(posedge clk) disable iff (reset)
    (c1_valid && c1_addr == dsm_base) |-> (c1_data == 64'd1))
    else report_mismatch("c1_data at dsm_base", $sampled(c1_data), 64'd1);
  completion_order_check: assert property (@(posedge clk) disable iff (reset)
    (c1_valid && c1_addr == dsm_base) |-> (wr_count == src_lines) && (dsm_count == 0))
    else report_error("completion write came early or more than once");

  task automatic run_test(input int t);
    int          errors_before;
    int          k;
    logic [63:0] got;
    logic [63:0] exp;
    errors_before = error_count;
    @(posedge clk);
    reset         <= 1'b1;
    hc_control    <= '0;
    src_lines     <= test_n[t];
    reverse_mode  <= test_rev[t];
    c0_af_pattern <= test_c0_pat[t];
    c1_af_pattern <= test_c1_pat[t];
    for (k = 0; k < 16; k++) begin
      src_data[k] = {lcg_next(), lcg_next()};
    end
    for (k = 0; k < 64; k++) begin
      host_i.load_line(16'(k), fill_line(k));
    end
    for (k = 0; k < 16; k++) begin
      host_i.load_line(src_base + 16'(k), src_data[k]);
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk); // Idle window before start.
    hc_control <= test_rev[t] ? hc_pkg::HC_CONTROL_START_REVERSE : hc_pkg::HC_CONTROL_START;
    while (dsm_count == 0) @(posedge clk);
    repeat (8) @(posedge clk);
    hc_control <= '0;
    @(posedge clk);
    for (k = 0; k < int'(test_n[t]); k++) begin
      exp = increment_words(src_data[test_rev[t] ? int'(test_n[t]) - 1 - k : k]);
      got = host_i.read_line(dst_base + 16'(k));
      assert (got == exp) else report_mismatch($sformatf("dst line %0d", k), got, exp);
    end
    got = host_i.read_line(dsm_base);
    assert (got == 64'd1) else report_mismatch("dsm word", got, 64'd1);
    assert (dsm_count == 16'd1) else report_error("completion write count is not one");
    if (error_count != errors_before) failed_tests++;
    $display("test %0d %s N=%0d c0_af=%h c1_af=%h: %s", t, test_rev[t] ? "reverse" : "copy",
             test_n[t], test_c0_pat[t], test_c1_pat[t],
             (error_count == errors_before) ? "ok" : "failed");
  endtask

  initial begin
    int t;
    rand_state    = 32'd85;
    error_count   = 0;
    failed_tests  = 0;
    cycle_count   = 0;
    cycle_limit   = 0;
    reset         <= 1'b1;
    hc_control    <= '0;
    src_base      <= 16'h0100;
    dst_base      <= 16'h0120;
    dsm_base      <= 16'h013F;
    src_lines     <= '0;
    reverse_mode  <= 1'b0;
    c0_af_pattern <= '0;
    c1_af_pattern <= '0;
    for (t = 0; t < NUM_TESTS; t++) begin
      test_n[t]      = 16'((lcg_next() >> 16) % 12 + 1);
      test_rev[t]    = (t == 3) || (t == 4) || (t == 6);
      test_c0_pat[t] = '0;
      test_c1_pat[t] = '0;
      case (t)
        0: test_n[t] = 16'd1;
        2, 4: test_n[t] = 16'd12;
        5, 6: begin
          test_c0_pat[t] = 16'(lcg_next() >> 8) & 16'hFFFE; // Keep one open slot.
          test_c1_pat[t] = 16'(lcg_next() >> 8) & 16'hFFFE;
        end
        7: begin
          test_n[t]      = 16'd16;
          test_c1_pat[t] = 16'hFFFE; // Writes drain slowly.
        end
        default: ;
      endcase
      cycle_limit += 40 * int'(test_n[t]) + 200;
    end
    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS, failed_tests, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : hc_tb

/* sources.f */
hc_pkg.sv
hc_buffers_if.sv
hc_fifo.sv
hc_line_core.sv
hc_requestor.sv
hc_top.sv
hc_host_model.sv
hc_tb.sv
